//--- wqm_vectors.txt
# qidx sq_base cq_base pd_vaddr cq_head prod_idx mtu_code opcode len rvaddr wr_id nack_after
# all hex, nack_after 0 means no nack
03 10000 20000 a0000000 0 1 0 00 80 5000000000 1111 0
03 10000 20000 a0000000 1 2 0 00 100 5000001000 1112 0
05 10000 20000 a1000000 2 3 1 00 700 5000002000 1113 0
07 10000 20000 a2000000 3 4 0 02 250 0 1114 0
07 10000 20000 a3000000 4 5 2 04 1234 6000000000 1115 0
09 10000 20000 a4000000 5 6 0 00 300 5000003000 1116 2
09 10000 20000 a5000000 6 7 1 04 600 6000001000 1117 2
0a 10000 20000 a6000000 7 8 0 09 40 5000004000 1118 0
0b 10000 20000 a7000000 8 9 7 00 1800 5000005000 1119 0

//--- flist.f
+incdir+.
wqm_pkg.sv
wqm_doorbell.sv
wqm_wqe_fetch.sv
wqm_segmenter.sv
wqm_completion.sv
wqm_top.sv
wqm_chk.sv
wqm_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --timing -Wno-fatal -f flist.f --top-module wqm_tb \
  -o wqm_sim > sim.log 2>&1 && ./obj_dir/wqm_sim >> sim.log 2>&1
cat sim.log
grep -q "^TEST OK$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- wqm_tb.sv
`timescale 1ns/1ns
`include "wqm_params.svh"

module wqm_tb;

  localparam int MAX_VEC     = 32;
  localparam int MAX_PKT     = 64;
  localparam int CYC_PER_VEC = 2000;

  logic                   axis_aclk_i;
  logic                   axis_rstn_i;
  logic                   sq_updated_i;
  logic [7:0]             qidx_i;
  logic [31:0]            sq_prod_idx_i;
  logic [31:0]            cq_head_i;
  logic [63:0]            sq_base_i;
  logic [63:0]            cq_base_i;
  logic [63:0]            pd_vaddr_i;
  logic [31:0]            qp_conf_i;
  logic                   busy_o;
  logic [63:0]            m_axi_araddr_o;
  logic                   m_axi_arvalid_o;
  logic                   m_axi_arready_i;
  logic [511:0]           m_axi_rdata_i;
  logic                   m_axi_rlast_i;
  logic                   m_axi_rvalid_i;
  logic                   m_axi_rready_o;
  logic                   sq_req_valid_o;
  logic                   sq_req_ready_i;
  logic [7:0]             sq_req_opcode_o;
  logic [23:0]            sq_req_qpn_o;
  logic [63:0]            sq_req_lvaddr_o;
  logic [63:0]            sq_req_rvaddr_o;
  logic [31:0]            sq_req_len_o;
  logic                   sq_req_last_o;
  logic                   rx_ack_valid_i;
  logic                   rx_nack_valid_i;
  logic                   rx_dat_valid_i;
  logic [63:0]            m_axi_awaddr_o;
  logic                   m_axi_awvalid_o;
  logic [511:0]           m_axi_wdata_o;
  logic [63:0]            m_axi_wstrb_o;
  logic                   m_axi_wlast_o;
  logic                   m_axi_wvalid_o;
  logic                   m_axi_bready_o;
  logic                   m_axi_awready_i;
  logic                   m_axi_wready_i;
  logic                   m_axi_bvalid_i;
  logic [39:0]            wb_cqhead_o;
  logic                   wb_cqhead_valid_o;

  // vector table and the test being run
  logic [63:0] vec [MAX_VEC][12];
  logic [63:0] fld [12];
  int          n_vec;
  logic        loaded;
  logic [7:0]  t_qidx;
  logic [63:0] t_sq_base;
  logic [63:0] t_cq_base;
  logic [63:0] t_pd;
  logic [31:0] t_head;
  logic [31:0] t_prod;
  logic [2:0]  t_code;
  logic [7:0]  t_op;
  logic [31:0] t_len;
  logic [63:0] t_rva;
  logic [15:0] t_wrid;
  int          t_nack;
  int          t_total;
  logic [7:0]  t_status;

  // expected packet requests
  logic [7:0]  e_op [MAX_PKT];
  logic [31:0] e_len [MAX_PKT];
  logic [63:0] e_lva [MAX_PKT];
  logic [63:0] e_rva [MAX_PKT];
  logic        e_last [MAX_PKT];
  int          n_exp;

  int          req_idx;
  int          owe;
  int          post_cnt;
  logic        nacked;
  logic        rd_pend;
  logic        b_pend;
  logic        cpl_seen;
  logic        busy_chk;
  logic [31:0] rng;
  int          errors;
  int          pass_cnt;
  int          fail_cnt;

  wqm_top UUT (.*);

  initial begin
    axis_aclk_i = 1'b0;
    forever #50 axis_aclk_i = ~axis_aclk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("Mismatch %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // expected requests from the segmentation rules

  task automatic build_expected();
    logic [31:0] mtu;
    logic [31:0] rem;
    logic [63:0] off;
    logic        send;
    mtu      = 32'd1 << (8 + ((t_code > 3'd4) ? 3'd4 : t_code));
    send     = (t_op == `WQM_WQE_SEND);
    n_exp    = 0;
    t_status = 8'd0;
    if (t_op == `WQM_WQE_WRITE || send) begin
      rem = t_len;
      off = 64'd0;
      while (rem > 0) begin
        e_len[n_exp]  = (rem > mtu) ? mtu : rem;
        e_last[n_exp] = (rem <= mtu);
        e_lva[n_exp]  = t_pd + off;
        e_rva[n_exp]  = send ? t_pd + off : t_rva + off;
        if (t_len <= mtu)
          e_op[n_exp] = send ? `WQM_RC_SEND_ONLY : `WQM_RC_WRITE_ONLY;
        else if (off == 0)
          e_op[n_exp] = send ? `WQM_RC_SEND_FIRST : `WQM_RC_WRITE_FIRST;
        else if (rem <= mtu)
          e_op[n_exp] = send ? `WQM_RC_SEND_LAST : `WQM_RC_WRITE_LAST;
        else
          e_op[n_exp] = send ? `WQM_RC_SEND_MIDDLE : `WQM_RC_WRITE_MIDDLE;
        rem = (rem > mtu) ? rem - mtu : 32'd0;
        off = off + 64'(mtu);
        n_exp++;
      end
      t_total = n_exp;
    end else if (t_op == `WQM_WQE_READ) begin
      e_op[0]  = `WQM_RC_READ_REQ;
      e_len[0] = t_len;
      e_last[0] = 1'b1;
      e_lva[0] = t_pd;
      e_rva[0] = t_rva;
      n_exp    = 1;
      t_total  = int'((t_len + mtu - 1) / mtu);
    end else begin
      t_total  = 0;
      t_status = 8'd1;
    end
  endtask

  task automatic check_request();
    assert (req_idx < n_exp) else begin
      $display("unexpected packet request %0d with opcode %h", req_idx, sq_req_opcode_o);
      errors++;
    end
    if (req_idx < n_exp) begin
      check_val("sq_req_opcode_o", sq_req_opcode_o, e_op[req_idx]);
      check_val("sq_req_len_o", sq_req_len_o, e_len[req_idx]);
      check_val("sq_req_lvaddr_o", sq_req_lvaddr_o, e_lva[req_idx]);
      check_val("sq_req_rvaddr_o", sq_req_rvaddr_o, e_rva[req_idx]);
      check_val("sq_req_last_o", sq_req_last_o, e_last[req_idx]);
      check_val("sq_req_qpn_o", sq_req_qpn_o, 64'(t_qidx));
    end
    req_idx++;
    owe += (t_op == `WQM_WQE_READ) ? t_total : 1;
  endtask

  ////////////////////////////////////////////////////////////
  // memory model and scoreboard, sampled on the rising edge

  always @(posedge axis_aclk_i) begin
    if (axis_rstn_i) begin
      if (busy_chk) begin
        check_val("busy_o", busy_o, 64'd0);
        busy_chk = 1'b0;
      end
      if (m_axi_arvalid_o && m_axi_arready_i) begin
        check_val("m_axi_araddr_o", m_axi_araddr_o, t_sq_base + (64'(t_head) << 6));
        rd_pend = 1'b1;
      end
      if (m_axi_rvalid_i && m_axi_rready_o)
        rd_pend = 1'b0;
      if (sq_req_valid_o && sq_req_ready_i)
        check_request();
      if (m_axi_awvalid_o && m_axi_awready_i) begin
        check_val("m_axi_awaddr_o", m_axi_awaddr_o, t_cq_base + (64'(t_head) << 2));
        check_val("request count", 64'(req_idx), 64'(n_exp));
        assert (post_cnt == t_total) else begin
          $display("completion written after %0d of %0d responses", post_cnt, t_total);
          errors++;
        end
      end
      if (m_axi_wvalid_o && m_axi_wready_i) begin
        check_val("m_axi_wdata_o", m_axi_wdata_o[31:0], {t_status, t_op, t_wrid});
        check_val("m_axi_wstrb_o", m_axi_wstrb_o, 64'hF);
        check_val("m_axi_wlast_o", m_axi_wlast_o, 64'd1);
        assert (m_axi_wdata_o[511:32] == '0) else begin
          $display("completion data has bits set above the 4 byte entry");
          errors++;
        end
        b_pend = 1'b1;
      end
      if (m_axi_bvalid_i && m_axi_bready_o)
        b_pend = 1'b0;
      if (wb_cqhead_valid_o) begin
        check_val("wb_cqhead_o", wb_cqhead_o, {24'd0, t_qidx, t_head + 32'd1});
        cpl_seen = 1'b1;
        busy_chk = 1'b1;
      end
    end
  end

  // random readies, read beat, write response and rx pulses
  always @(negedge axis_aclk_i) begin
    if (axis_rstn_i) begin
      rng             = xorshift(rng);
      m_axi_arready_i = rng[0] | rng[1];
      sq_req_ready_i  = rng[2] | rng[3];
      m_axi_awready_i = rng[4] | rng[5];
      m_axi_wready_i  = rng[6] | rng[7];
      m_axi_rvalid_i  = rd_pend && (m_axi_rvalid_i || rng[8]);
      m_axi_rlast_i   = m_axi_rvalid_i;
      m_axi_bvalid_i  = b_pend && (m_axi_bvalid_i || rng[9]);
      rx_ack_valid_i  = 1'b0;
      rx_nack_valid_i = 1'b0;
      rx_dat_valid_i  = 1'b0;
      if (owe > 0 && rng[10]) begin
        if (t_nack != 0 && !nacked && post_cnt == t_nack) begin
          // everything sent so far has to come again
          rx_nack_valid_i = 1'b1;
          nacked          = 1'b1;
          owe             = owe + post_cnt;
          post_cnt        = 0;
        end else begin
          rx_dat_valid_i = (t_op == `WQM_WQE_READ);
          rx_ack_valid_i = (t_op != `WQM_WQE_READ);
          owe            = owe - 1;
          post_cnt       = post_cnt + 1;
        end
      end
    end
  end

  task automatic load_vectors();
    int    fd;
    string line;
    fd = $fopen("wqm_vectors.txt", "r");
    assert (fd != 0) else begin
      $display("cannot open wqm_vectors.txt");
      errors++;
    end
    while (fd != 0 && !$feof(fd) && n_vec < MAX_VEC) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line[0] != "#") begin
        if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
                    fld[3], fld[4], fld[5], fld[6], fld[7], fld[8], fld[9], fld[10],
                    fld[11]) == 12) begin
          for (int c = 0; c < 12; c++)
            vec[n_vec][c] = fld[c];
          n_vec++;
        end
      end
    end
    if (fd != 0)
      $fclose(fd);
  endtask

  task automatic run_vector(input int i);
    int          err0;
    logic [511:0] raw;
    err0      = errors;
    t_qidx    = vec[i][0][7:0];
    t_sq_base = vec[i][1];
    t_cq_base = vec[i][2];
    t_pd      = vec[i][3];
    t_head    = vec[i][4][31:0];
    t_prod    = vec[i][5][31:0];
    t_code    = vec[i][6][2:0];
    t_op      = vec[i][7][7:0];
    t_len     = vec[i][8][31:0];
    t_rva     = vec[i][9];
    t_wrid    = vec[i][10][15:0];
    t_nack    = int'(vec[i][11]);
    build_expected();
    // reserved bits carry the full wqe address
    raw           = {8{t_sq_base + (64'(t_head) << 6)}};
    raw[15:0]     = t_wrid;
    raw[127:96]   = t_len;
    raw[135:128]  = t_op;
    raw[223:160]  = t_rva;
    raw[255:224]  = ~{t_wrid, t_wrid};
    m_axi_rdata_i = raw;
    req_idx  = 0;
    owe      = 0;
    post_cnt = 0;
    nacked   = 1'b0;
    cpl_seen = 1'b0;
    @(negedge axis_aclk_i);
    qidx_i        = t_qidx;
    sq_base_i     = t_sq_base;
    cq_base_i     = t_cq_base;
    pd_vaddr_i    = t_pd;
    cq_head_i     = t_head;
    sq_prod_idx_i = t_prod;
    qp_conf_i     = {21'd0, t_code, 8'd0};
    sq_updated_i  = 1'b1;
    @(negedge axis_aclk_i);
    sq_updated_i = 1'b0;
    wait (cpl_seen);
    @(posedge axis_aclk_i);
    @(negedge axis_aclk_i);
    check_val("request count", 64'(req_idx), 64'(n_exp));
    if (errors == err0)
      pass_cnt++;
    else
      fail_cnt++;
    $display("test %0d opcode %h len %0d: %s", i, t_op, t_len,
             (errors == err0) ? "ok" : "errors");
  endtask

  initial begin
    axis_rstn_i     = 1'b0;
    sq_updated_i    = 1'b0;
    qidx_i          = '0;
    sq_prod_idx_i   = '0;
    cq_head_i       = '0;
    sq_base_i       = '0;
    cq_base_i       = '0;
    pd_vaddr_i      = '0;
    qp_conf_i       = '0;
    m_axi_arready_i = 1'b0;
    m_axi_rdata_i   = '0;
    m_axi_rlast_i   = 1'b0;
    m_axi_rvalid_i  = 1'b0;
    sq_req_ready_i  = 1'b0;
    rx_ack_valid_i  = 1'b0;
    rx_nack_valid_i = 1'b0;
    rx_dat_valid_i  = 1'b0;
    m_axi_awready_i = 1'b0;
    m_axi_wready_i  = 1'b0;
    m_axi_bvalid_i  = 1'b0;
    rng      = 32'hf98cefea;
    rd_pend  = 1'b0;
    b_pend   = 1'b0;
    busy_chk = 1'b0;
    cpl_seen = 1'b0;
    t_nack   = 0;
    owe      = 0;
    errors   = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    n_vec    = 0;
    loaded   = 1'b0;
    load_vectors();
    loaded = 1'b1;
    repeat (10) @(posedge axis_aclk_i);
    @(negedge axis_aclk_i);
    axis_rstn_i = 1'b1;
    for (int i = 0; i < n_vec; i++)
      run_vector(i);
    $display("tests %0d passed %0d failed %0d errors %0d", n_vec, pass_cnt, fail_cnt, errors);
    if (errors == 0 && n_vec > 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog sized by the number of vectors
  initial begin
    wait (loaded);
    repeat (CYC_PER_VEC * (n_vec + 1)) @(posedge axis_aclk_i);
    $display("timeout waiting for a completion");
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- wqm_chk.sv
`timescale 1ns/1ns
`include "wqm_params.svh"

module wqm_chk (
  input logic                       axis_aclk_i,
  input logic                       axis_rstn_i,
  input logic                       busy_o,
  input logic                       m_axi_arvalid_o,
  input logic                       m_axi_arready_i,
  input logic [`WQM_ADDR_W-1:0]     m_axi_araddr_o,
  input logic                       m_axi_rready_o,
  input logic                       sq_req_valid_o,
  input logic                       sq_req_ready_i,
  input logic [7:0]                 sq_req_opcode_o,
  input logic [`WQM_ADDR_W-1:0]     sq_req_lvaddr_o,
  input logic [`WQM_ADDR_W-1:0]     sq_req_rvaddr_o,
  input logic [`WQM_LEN_W-1:0]      sq_req_len_o,
  input logic                       sq_req_last_o,
  input logic                       m_axi_awvalid_o,
  input logic                       m_axi_awready_i,
  input logic [`WQM_ADDR_W-1:0]     m_axi_awaddr_o,
  input logic                       m_axi_wvalid_o,
  input logic                       m_axi_wready_i,
  input logic [`WQM_BEAT_W-1:0]     m_axi_wdata_o,
  input logic                       wb_cqhead_valid_o
);

  ////////////////////////////////////////////////////////////
  // held valids keep their data

  req_hold: assert property (@(posedge axis_aclk_i) disable iff (!axis_rstn_i)
    sq_req_valid_o && !sq_req_ready_i |=> sq_req_valid_o && $stable(sq_req_opcode_o)
    && $stable(sq_req_lvaddr_o) && $stable(sq_req_rvaddr_o) && $stable(sq_req_len_o)
    && $stable(sq_req_last_o))
    else $error("packet request changed while waiting for ready");

  ar_hold: assert property (@(posedge axis_aclk_i) disable iff (!axis_rstn_i)
    m_axi_arvalid_o && !m_axi_arready_i |=> m_axi_arvalid_o && $stable(m_axi_araddr_o))
    else $error("read address changed while waiting for arready");

  aw_hold: assert property (@(posedge axis_aclk_i) disable iff (!axis_rstn_i)
    m_axi_awvalid_o && !m_axi_awready_i |=> m_axi_awvalid_o && $stable(m_axi_awaddr_o))
    else $error("write address changed while waiting for awready");

  w_hold: assert property (@(posedge axis_aclk_i) disable iff (!axis_rstn_i)
    m_axi_wvalid_o && !m_axi_wready_i |=> m_axi_wvalid_o && $stable(m_axi_wdata_o))
    else $error("write data changed while waiting for wready");

  // everything quiet in reset
  rst_low: assert property (@(posedge axis_aclk_i)
    !axis_rstn_i |-> !busy_o && !m_axi_arvalid_o && !m_axi_rready_o && !m_axi_awvalid_o
    && !m_axi_wvalid_o && !sq_req_valid_o && !wb_cqhead_valid_o)
    else $error("valid output high during reset");

endmodule

bind wqm_top wqm_chk u_chk (.*);

//--- wqm_top.sv
`timescale 1ns/1ns
`include "wqm_params.svh"

module wqm_top (
  input  logic                       axis_aclk_i,
  input  logic                       axis_rstn_i,
  input  logic                       sq_updated_i,
  input  logic [`WQM_QIDX_W-1:0]     qidx_i,
  input  logic [`WQM_IDX_W-1:0]      sq_prod_idx_i,
  input  logic [`WQM_IDX_W-1:0]      cq_head_i,
  input  logic [`WQM_ADDR_W-1:0]     sq_base_i,
  input  logic [`WQM_ADDR_W-1:0]     cq_base_i,
  input  logic [`WQM_ADDR_W-1:0]     pd_vaddr_i,
  input  logic [31:0]                qp_conf_i,
  output logic                       busy_o,
  output logic [`WQM_ADDR_W-1:0]     m_axi_araddr_o,
  output logic                       m_axi_arvalid_o,
  input  logic                       m_axi_arready_i,
  input  logic [`WQM_BEAT_W-1:0]     m_axi_rdata_i,
  input  logic                       m_axi_rlast_i,
  input  logic                       m_axi_rvalid_i,
  output logic                       m_axi_rready_o,
  output logic                       sq_req_valid_o,
  input  logic                       sq_req_ready_i,
  output logic [7:0]                 sq_req_opcode_o,
  output logic [23:0]                sq_req_qpn_o,
  output logic [`WQM_ADDR_W-1:0]     sq_req_lvaddr_o,
  output logic [`WQM_ADDR_W-1:0]     sq_req_rvaddr_o,
  output logic [`WQM_LEN_W-1:0]      sq_req_len_o,
  output logic                       sq_req_last_o,
  input  logic                       rx_ack_valid_i,
  input  logic                       rx_nack_valid_i,
  input  logic                       rx_dat_valid_i,
  output logic [`WQM_ADDR_W-1:0]     m_axi_awaddr_o,
  output logic                       m_axi_awvalid_o,
  output logic [`WQM_BEAT_W-1:0]     m_axi_wdata_o,
  output logic [`WQM_BEAT_W/8-1:0]   m_axi_wstrb_o,
  output logic                       m_axi_wlast_o,
  output logic                       m_axi_wvalid_o,
  output logic                       m_axi_bready_o,
  input  logic                       m_axi_awready_i,
  input  logic                       m_axi_wready_i,
  input  logic                       m_axi_bvalid_i,
  output logic [`WQM_QIDX_W+`WQM_IDX_W-1:0] wb_cqhead_o,
  output logic                       wb_cqhead_valid_o
);

  logic                   fetch_start;
  logic [`WQM_ADDR_W-1:0] wqe_addr;
  logic [`WQM_IDX_W-1:0]  cur_idx;
  logic [`WQM_QIDX_W-1:0] db_qidx;
  logic [`WQM_ADDR_W-1:0] db_cq_base;
  logic [`WQM_ADDR_W-1:0] db_pd_vaddr;
  logic [3:0]             mtu_log;
  wqm_pkg::wqe_u          wqe;
  logic                   wqe_valid;
  logic                   seg_done;
  logic [`WQM_IDX_W-1:0]  exp_resp;
  logic                   is_read;
  logic [7:0]             status;
  logic                   cq_done;

  // outside ports connect by name
  wqm_doorbell u_doorbell (
    .*,
    .cq_done_i     (cq_done),
    .fetch_start_o (fetch_start),
    .wqe_addr_o    (wqe_addr),
    .cur_idx_o     (cur_idx),
    .qidx_o        (db_qidx),
    .cq_base_o     (db_cq_base),
    .pd_vaddr_o    (db_pd_vaddr),
    .mtu_log_o     (mtu_log)
  );

  wqm_wqe_fetch u_fetch (
    .*,
    .fetch_start_i (fetch_start),
    .wqe_addr_i    (wqe_addr),
    .wqe_o         (wqe),
    .wqe_valid_o   (wqe_valid)
  );

  wqm_segmenter u_segmenter (
    .*,
    .wqe_i         (wqe),
    .wqe_valid_i   (wqe_valid),
    .qidx_i        (db_qidx),
    .pd_vaddr_i    (db_pd_vaddr),
    .mtu_log_i     (mtu_log),
    .seg_done_o    (seg_done),
    .exp_resp_o    (exp_resp),
    .is_read_o     (is_read),
    .status_o      (status)
  );

  wqm_completion u_completion (
    .*,
    .seg_done_i    (seg_done),
    .exp_resp_i    (exp_resp),
    .is_read_i     (is_read),
    .status_i      (status),
    .wqe_i         (wqe),
    .cur_idx_i     (cur_idx),
    .qidx_i        (db_qidx),
    .cq_base_i     (db_cq_base),
    .cq_done_o     (cq_done)
  );

endmodule

//--- wqm_completion.sv
`timescale 1ns/1ns
`include "wqm_params.svh"

module wqm_completion (
  input  logic                       axis_aclk_i,
  input  logic                       axis_rstn_i,
  input  logic                       seg_done_i,
  input  logic [`WQM_IDX_W-1:0]      exp_resp_i,
  input  logic                       is_read_i,
  input  logic [7:0]                 status_i,
  input  wqm_pkg::wqe_u              wqe_i,
  input  logic [`WQM_IDX_W-1:0]      cur_idx_i,
  input  logic [`WQM_QIDX_W-1:0]     qidx_i,
  input  logic [`WQM_ADDR_W-1:0]     cq_base_i,
  input  logic                       rx_ack_valid_i,
  input  logic                       rx_nack_valid_i,
  input  logic                       rx_dat_valid_i,
  output logic [`WQM_ADDR_W-1:0]     m_axi_awaddr_o,
  output logic                       m_axi_awvalid_o,
  output logic [`WQM_BEAT_W-1:0]     m_axi_wdata_o,
  output logic [`WQM_BEAT_W/8-1:0]   m_axi_wstrb_o,
  output logic                       m_axi_wlast_o,
  output logic                       m_axi_wvalid_o,
  output logic                       m_axi_bready_o,
  input  logic                       m_axi_awready_i,
  input  logic                       m_axi_wready_i,
  input  logic                       m_axi_bvalid_i,
  output logic [`WQM_QIDX_W+`WQM_IDX_W-1:0] wb_cqhead_o,
  output logic                       wb_cqhead_valid_o,
  output logic                       cq_done_o
);

  localparam int STRB_W = `WQM_BEAT_W / 8;

  typedef enum logic [2:0] {C_IDLE, C_WAIT, C_AW, C_W, C_B} cpl_state_t;
  cpl_state_t state_q;

  logic [`WQM_IDX_W-1:0] resp_cnt_q;
  logic                  resp_hit;
  logic                  counting;

  // read data beats count for reads, acks otherwise
  assign resp_hit = is_read_i ? rx_dat_valid_i : rx_ack_valid_i;
  assign counting = (state_q == C_IDLE) || (state_q == C_WAIT);

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      state_q    <= C_IDLE;
      resp_cnt_q <= '0;
      cq_done_o  <= 1'b0;
    end else begin
      cq_done_o <= 1'b0;
      if (rx_nack_valid_i) begin
        resp_cnt_q <= '0;
      end else if (resp_hit && counting) begin
        resp_cnt_q <= resp_cnt_q + 1'b1;
      end
      case (state_q)
        C_IDLE: if (seg_done_i) state_q <= C_WAIT;
        C_WAIT: if (resp_cnt_q == exp_resp_i) state_q <= C_AW;
        C_AW:   if (m_axi_awready_i) state_q <= C_W;
        C_W:    if (m_axi_wready_i) state_q <= C_B;
        C_B: begin
          if (m_axi_bvalid_i) begin
            state_q    <= C_IDLE;
            cq_done_o  <= 1'b1;
            resp_cnt_q <= '0;
          end
        end
        default: state_q <= C_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // cq entry write, single 4 byte beat

  assign m_axi_awvalid_o = (state_q == C_AW);
  assign m_axi_awaddr_o  = cq_base_i + (`WQM_ADDR_W'(cur_idx_i) << `WQM_CQE_LOG);
  assign m_axi_wvalid_o  = (state_q == C_W);
  assign m_axi_wlast_o   = (state_q == C_W);
  assign m_axi_wdata_o   = `WQM_BEAT_W'({status_i, wqe_i.f.opcode, wqe_i.f.wr_id});
  assign m_axi_wstrb_o   = STRB_W'(4'hF);
  assign m_axi_bready_o  = (state_q == C_B);

  // new head is the entry just written plus one
  assign wb_cqhead_o       = {qidx_i, cur_idx_i + 1'b1};
  assign wb_cqhead_valid_o = cq_done_o;

endmodule

//--- wqm_segmenter.sv
`timescale 1ns/1ns
`include "wqm_params.svh"

module wqm_segmenter (
  input  logic                   axis_aclk_i,
  input  logic                   axis_rstn_i,
  input  wqm_pkg::wqe_u          wqe_i,
  input  logic                   wqe_valid_i,
  input  logic [`WQM_QIDX_W-1:0] qidx_i,
  input  logic [`WQM_ADDR_W-1:0] pd_vaddr_i,
  input  logic [3:0]             mtu_log_i,
  output logic                   sq_req_valid_o,
  input  logic                   sq_req_ready_i,
  output logic [7:0]             sq_req_opcode_o,
  output logic [23:0]            sq_req_qpn_o,
  output logic [`WQM_ADDR_W-1:0] sq_req_lvaddr_o,
  output logic [`WQM_ADDR_W-1:0] sq_req_rvaddr_o,
  output logic [`WQM_LEN_W-1:0]  sq_req_len_o,
  output logic                   sq_req_last_o,
  output logic                   seg_done_o,
  output logic [`WQM_IDX_W-1:0]  exp_resp_o,
  output logic                   is_read_o,
  output logic [7:0]             status_o
);

  logic [`WQM_LEN_W-1:0] mtu;
  logic [`WQM_LEN_W-1:0] len;
  logic [7:0]            wqe_op;
  logic                  op_send;
  logic                  op_read;
  logic                  op_ok;
  logic                  accept;
  logic                  is_send_q;
  logic [`WQM_LEN_W-1:0] rem_q;
  logic [`WQM_IDX_W-1:0] rd_resp;

  assign mtu     = `WQM_LEN_W'(1) << mtu_log_i;
  assign len     = wqe_i.f.len;
  assign wqe_op  = wqe_i.f.opcode;
  assign op_send = (wqe_op == `WQM_WQE_SEND);
  assign op_read = (wqe_op == `WQM_WQE_READ);
  assign op_ok   = op_send || op_read || (wqe_op == `WQM_WQE_WRITE);
  assign accept  = sq_req_valid_o && sq_req_ready_i;

  // read responses, len / mtu rounded up
  assign rd_resp = (len >> mtu_log_i) + `WQM_IDX_W'(|(len & (mtu - 1'b1)));

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      sq_req_valid_o <= 1'b0;
      seg_done_o     <= 1'b0;
    end else begin
      seg_done_o <= 1'b0;
      if (wqe_valid_i) begin
        // bad opcode skips straight to completion
        sq_req_valid_o <= op_ok;
        seg_done_o     <= !op_ok;
      end else if (accept && sq_req_last_o) begin
        sq_req_valid_o <= 1'b0;
        seg_done_o     <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // request fields, stepped on each accept

  always_ff @(posedge axis_aclk_i) begin
    if (wqe_valid_i) begin
      is_send_q       <= op_send;
      is_read_o       <= op_read;
      status_o        <= op_ok ? 8'd0 : 8'd1;
      sq_req_qpn_o    <= 24'(qidx_i);
      sq_req_lvaddr_o <= pd_vaddr_i;
      // send has no remote buffer
      sq_req_rvaddr_o <= op_send ? pd_vaddr_i : wqe_i.f.rvaddr;
      rem_q           <= len - mtu;
      if (!op_ok) begin
        exp_resp_o <= '0;
      end else if (op_read) begin
        sq_req_opcode_o <= `WQM_RC_READ_REQ;
        sq_req_len_o    <= len;
        sq_req_last_o   <= 1'b1;
        exp_resp_o      <= rd_resp;
      end else if (len <= mtu) begin
        sq_req_opcode_o <= op_send ? `WQM_RC_SEND_ONLY : `WQM_RC_WRITE_ONLY;
        sq_req_len_o    <= len;
        sq_req_last_o   <= 1'b1;
        exp_resp_o      <= `WQM_IDX_W'(1);
      end else begin
        sq_req_opcode_o <= op_send ? `WQM_RC_SEND_FIRST : `WQM_RC_WRITE_FIRST;
        sq_req_len_o    <= mtu;
        sq_req_last_o   <= 1'b0;
        exp_resp_o      <= `WQM_IDX_W'(1);
      end
    end else if (accept && !sq_req_last_o) begin
      sq_req_lvaddr_o <= sq_req_lvaddr_o + `WQM_ADDR_W'(mtu);
      sq_req_rvaddr_o <= sq_req_rvaddr_o + `WQM_ADDR_W'(mtu);
      exp_resp_o      <= exp_resp_o + 1'b1;
      rem_q           <= rem_q - mtu;
      if (rem_q <= mtu) begin
        sq_req_opcode_o <= is_send_q ? `WQM_RC_SEND_LAST : `WQM_RC_WRITE_LAST;
        sq_req_len_o    <= rem_q;
        sq_req_last_o   <= 1'b1;
      end else begin
        sq_req_opcode_o <= is_send_q ? `WQM_RC_SEND_MIDDLE : `WQM_RC_WRITE_MIDDLE;
        sq_req_len_o    <= mtu;
        sq_req_last_o   <= 1'b0;
      end
    end
  end

endmodule

//--- wqm_wqe_fetch.sv
`timescale 1ns/1ns
`include "wqm_params.svh"

module wqm_wqe_fetch (
  input  logic                   axis_aclk_i,
  input  logic                   axis_rstn_i,
  input  logic                   fetch_start_i,
  input  logic [`WQM_ADDR_W-1:0] wqe_addr_i,
  output logic [`WQM_ADDR_W-1:0] m_axi_araddr_o,
  output logic                   m_axi_arvalid_o,
  input  logic                   m_axi_arready_i,
  input  logic [`WQM_BEAT_W-1:0] m_axi_rdata_i,
  input  logic                   m_axi_rlast_i,
  input  logic                   m_axi_rvalid_i,
  output logic                   m_axi_rready_o,
  output wqm_pkg::wqe_u          wqe_o,
  output logic                   wqe_valid_o
);

  // one beat per read, arlen 0 and arsize 6
  localparam int AR_SIZE = 6;

  typedef enum logic [1:0] {F_IDLE, F_ADDR, F_DATA} fetch_state_t;
  fetch_state_t state_q;

  assign m_axi_arvalid_o = (state_q == F_ADDR);
  assign m_axi_rready_o  = (state_q == F_DATA);

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      state_q     <= F_IDLE;
      wqe_valid_o <= 1'b0;
    end else begin
      wqe_valid_o <= 1'b0;
      case (state_q)
        F_IDLE: if (fetch_start_i) state_q <= F_ADDR;
        F_ADDR: if (m_axi_arready_i) state_q <= F_DATA;
        F_DATA: begin
          if (m_axi_rvalid_i && m_axi_rlast_i) begin
            state_q     <= F_IDLE;
            wqe_valid_o <= 1'b1;
          end
        end
        default: state_q <= F_IDLE;
      endcase
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (state_q == F_IDLE && fetch_start_i) begin
      // beat aligned
      m_axi_araddr_o <= {wqe_addr_i[`WQM_ADDR_W-1:AR_SIZE], {AR_SIZE{1'b0}}};
    end
    if (state_q == F_DATA && m_axi_rvalid_i) begin
      wqe_o.raw <= m_axi_rdata_i;
    end
  end

endmodule

//--- wqm_doorbell.sv
`timescale 1ns/1ns
`include "wqm_params.svh"

module wqm_doorbell (
  input  logic                   axis_aclk_i,
  input  logic                   axis_rstn_i,
  input  logic                   sq_updated_i,
  input  logic [`WQM_QIDX_W-1:0] qidx_i,
  input  logic [`WQM_IDX_W-1:0]  sq_prod_idx_i,
  input  logic [`WQM_IDX_W-1:0]  cq_head_i,
  input  logic [`WQM_ADDR_W-1:0] sq_base_i,
  input  logic [`WQM_ADDR_W-1:0] cq_base_i,
  input  logic [`WQM_ADDR_W-1:0] pd_vaddr_i,
  input  logic [31:0]            qp_conf_i,
  input  logic                   cq_done_i,
  output logic                   busy_o,
  output logic                   fetch_start_o,
  output logic [`WQM_ADDR_W-1:0] wqe_addr_o,
  output logic [`WQM_IDX_W-1:0]  cur_idx_o,
  output logic [`WQM_QIDX_W-1:0] qidx_o,
  output logic [`WQM_ADDR_W-1:0] cq_base_o,
  output logic [`WQM_ADDR_W-1:0] pd_vaddr_o,
  output logic [3:0]             mtu_log_o
);

  logic                   capture;
  logic                   has_work;
  logic                   empty_q;
  logic [`WQM_IDX_W-1:0]  prod_q;
  logic [`WQM_IDX_W-1:0]  next_idx;
  logic [`WQM_ADDR_W-1:0] sq_base_q;
  logic [2:0]             mtu_code;

  assign capture  = sq_updated_i && !busy_o;
  assign has_work = cq_head_i < sq_prod_idx_i;
  assign next_idx = cur_idx_o + 1'b1;

  // codes above 4096 bytes are clamped
  assign mtu_code = (qp_conf_i[10:8] > 3'(`WQM_MTU_CODE_MAX)) ?
                    3'(`WQM_MTU_CODE_MAX) : qp_conf_i[10:8];

  assign wqe_addr_o = sq_base_q + (`WQM_ADDR_W'(cur_idx_o) << `WQM_WQE_LOG);

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      busy_o        <= 1'b0;
      fetch_start_o <= 1'b0;
      empty_q       <= 1'b0;
    end else begin
      fetch_start_o <= 1'b0;
      empty_q       <= 1'b0;
      if (capture) begin
        busy_o        <= 1'b1;
        fetch_start_o <= has_work;
        empty_q       <= !has_work;
      end else if (empty_q) begin
        busy_o <= 1'b0;
      end else if (cq_done_i) begin
        // next wqe or back to idle
        if (next_idx < prod_q) begin
          fetch_start_o <= 1'b1;
        end else begin
          busy_o <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (capture) begin
      qidx_o     <= qidx_i;
      prod_q     <= sq_prod_idx_i;
      cur_idx_o  <= cq_head_i;
      sq_base_q  <= sq_base_i;
      cq_base_o  <= cq_base_i;
      pd_vaddr_o <= pd_vaddr_i;
      mtu_log_o  <= 4'(`WQM_MTU_LOG_MIN) + 4'(mtu_code);
    end else if (cq_done_i) begin
      cur_idx_o <= next_idx;
    end
  end

endmodule

//--- wqm_pkg.sv
`include "wqm_params.svh"

package wqm_pkg;

  // 64 byte work queue element
  typedef struct packed {
    logic [`WQM_BEAT_W-1:256] rsvd_hi;
    logic [31:0]              rkey;
    logic [`WQM_ADDR_W-1:0]   rvaddr;
    logic [23:0]              rsvd_op;
    logic [7:0]               opcode;
    logic [`WQM_LEN_W-1:0]    len;
    logic [79:0]              rsvd_lo;
    logic [15:0]              wr_id;
  } wqe_fields_t;

  // raw read beat or decoded fields
  typedef union packed {
    logic [`WQM_BEAT_W-1:0] raw;
    wqe_fields_t            f;
  } wqe_u;

endpackage

//--- wqm_params.svh
`ifndef WQM_PARAMS_SVH
`define WQM_PARAMS_SVH

// datapath widths
`define WQM_ADDR_W        64
`define WQM_BEAT_W        512
`define WQM_LEN_W         32
`define WQM_QIDX_W        8
`define WQM_IDX_W         32

// log2 of byte sizes
`define WQM_WQE_LOG       6
`define WQM_CQE_LOG       2
`define WQM_MTU_LOG_MIN   8
`define WQM_MTU_CODE_MAX  4

// wqe opcodes
`define WQM_WQE_WRITE     8'h00
`define WQM_WQE_SEND      8'h02
`define WQM_WQE_READ      8'h04

// rc packet opcodes (ib spec values)
`define WQM_RC_SEND_FIRST    8'h00
`define WQM_RC_SEND_MIDDLE   8'h01
`define WQM_RC_SEND_LAST     8'h02
`define WQM_RC_SEND_ONLY     8'h04
`define WQM_RC_WRITE_FIRST   8'h06
`define WQM_RC_WRITE_MIDDLE  8'h07
`define WQM_RC_WRITE_LAST    8'h08
`define WQM_RC_WRITE_ONLY    8'h0A
`define WQM_RC_READ_REQ      8'h0C

`endif
